/* tb/stack_bank_stim.txt */
# columns: dir (1 write, 0 read), addr, wdata, expected rdata, expected pslverr, all hex
# addr holds the stack index in bits 7:4 and the op code in bits 3:0
0 0b 0000 0000 0
0 1b 0000 0000 0
0 2b 0000 0000 0
0 3b 0000 0000 0
0 08 0000 0000 1
1 00 1111 0000 0
1 00 2222 0000 0
1 10 aaaa 0000 0
0 0b 0000 0002 0
0 1b 0000 0001 0
0 08 0000 2222 0
0 18 0000 aaaa 0
0 08 0000 1111 0
0 0b 0000 0000 0
1 20 0005 0000 0
1 20 0007 0000 0
1 21 0009 0000 0
0 2a 0000 0005 0
0 2b 0000 0002 0
0 29 0000 0009 0
1 22 0000 0000 0
0 29 0000 000e 0
1 23 0000 0000 0
0 29 0000 fff7 0
1 24 0000 0000 0
0 29 0000 0005 0
1 25 0000 0000 0
0 29 0000 0005 0
1 26 0000 0000 0
0 29 0000 0000 0
0 2a 0000 0005 0
0 2b 0000 0002 0
1 30 0003 0000 0
1 32 0000 0000 1
0 39 0000 0003 0
0 3b 0000 0001 0
1 00 0042 0000 0
1 07 1234 0000 1
0 0c 0000 0000 1
0 48 0000 0000 1
1 40 5555 0000 1
0 00 0000 0000 1
1 08 0000 0000 1
0 0a 0000 0000 1
0 0b 0000 0001 0
0 09 0000 0042 0

/* vlog.f */
logic/stack_pkg.sv
logic/lifo.sv
logic/apb_stack_decode.sv
logic/stack_alu.sv
logic/stack_bank_top.sv
tb/stack_bank_properties.sv
tb/stack_bank_tb.sv

/* run_verilator.sh */
#!/bin/sh
# build the stack bank testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module stack_bank_tb \
    -Mdir obj_dir -o stack_bank_sim \
    -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/stack_bank_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

/* tb/stack_bank_tb.sv */
// testbench for the APB stack bank
// replays the stim file through an APB master and checks against a stack model,
// then overfills one stack and runs seeded random traffic

module stack_bank_tb;

    localparam int    DATA_W     = 16;
    localparam int    DEPTH      = 12;
    localparam int    NUM_STACKS = 4;
    localparam int    ADDR_W     = stack_pkg::ADDR_W;
    localparam int    N_FILL     = 2 * DEPTH + 5;      // overfill pushes, pops, two counts
    localparam int    N_RANDOM   = 200;
    localparam string STIM_FILE  = "tb/stack_bank_stim.txt";

    logic              i_clk;
    logic              i_reset;
    logic              i_psel;
    logic              i_penable;
    logic              i_pwrite;
    logic [ADDR_W-1:0] i_paddr;
    logic [DATA_W-1:0] i_pwdata;
    logic [DATA_W-1:0] o_prdata;
    logic              o_pready;
    logic              o_pslverr;

    logic [DATA_W-1:0] m_elem [NUM_STACKS][DEPTH];     // model, [s][0] is the top
    int                m_count [NUM_STACKS];

    logic              q_wr [$];                       // stim file columns
    logic [ADDR_W-1:0] q_addr [$];
    logic [DATA_W-1:0] q_wd [$];
    logic [DATA_W-1:0] q_rd [$];
    logic              q_er [$];

    string             line;
    int                fd;
    int                pick;
    bit                stim_ready;
    integer            seed;
    logic              f_wr;
    logic              f_er;
    logic              m_er;
    logic [ADDR_W-1:0] f_addr;
    logic [DATA_W-1:0] f_wd;
    logic [DATA_W-1:0] f_rd;
    logic [DATA_W-1:0] m_rd;
    logic [3:0]        r_op;
    logic [3:0]        r_sel;
    logic              r_wr;
    logic [DATA_W-1:0] r_wd;

    stack_bank_top #(
        .DATA_W     (DATA_W),
        .DEPTH      (DEPTH),
        .NUM_STACKS (NUM_STACKS)
    ) dut (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr)
    );

    always #50 i_clk = ~i_clk;                         // 100 unit period

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Test failures found");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            $display("Test failures found");
            $fatal(1, "one-bit output mismatch");
        end
    endtask

    // reference stack model, applies one transfer and gives the expected answer
    task automatic model_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wd,
                              output logic [DATA_W-1:0] rd, output logic er);
        logic [3:0]        op;
        int                sel;
        int                need;
        logic              is_wr;
        logic [DATA_W-1:0] s0;
        logic [DATA_W-1:0] s1;
        op    = addr[3:0];
        sel   = int'(addr[ADDR_W-1:stack_pkg::SEL_LSB]);
        is_wr = (op < 4'h7);                           // write codes 0..6
        need  = 0;
        er    = 1'b0;
        rd    = '0;
        if (op == 4'h1 || op == stack_pkg::OP_POP || op == stack_pkg::OP_PEEK0) begin
            need = 1;
        end else if ((op >= 4'h2 && op <= 4'h6) || op == stack_pkg::OP_PEEK1) begin
            need = 2;                                  // alu ops and second peek
        end
        if (op == 4'h7 || op > 4'hb || is_wr != wr || sel >= NUM_STACKS) begin
            er = 1'b1;
        end else if (m_count[sel] < need) begin
            er = 1'b1;
        end
        if (!er) begin
            s0 = m_elem[sel][0];
            s1 = m_elem[sel][1];
            case (op)
                stack_pkg::OP_PUSH: begin
                    for (int i = DEPTH - 1; i > 0; i--) begin
                        m_elem[sel][i] = m_elem[sel][i-1];
                    end
                    m_elem[sel][0] = wd;
                    if (m_count[sel] < DEPTH) begin
                        m_count[sel]++;                // bottom lost when full
                    end
                end
                stack_pkg::OP_REPL: m_elem[sel][0] = wd;
                stack_pkg::OP_ADD:  m_elem[sel][0] = s1 + s0;
                stack_pkg::OP_SUB:  m_elem[sel][0] = s1 - s0;
                stack_pkg::OP_AND:  m_elem[sel][0] = s1 & s0;
                stack_pkg::OP_OR:   m_elem[sel][0] = s1 | s0;
                stack_pkg::OP_XOR:  m_elem[sel][0] = s1 ^ s0;
                stack_pkg::OP_POP: begin
                    rd = s0;
                    for (int i = 0; i < DEPTH - 1; i++) begin
                        m_elem[sel][i] = m_elem[sel][i+1];
                    end
                    m_count[sel]--;
                end
                stack_pkg::OP_PEEK0: rd = s0;
                stack_pkg::OP_PEEK1: rd = s1;
                default:             rd = DATA_W'(m_count[sel]);  // count read
            endcase
        end
    endtask

    // one APB transfer, setup then access until pready
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wd,
                            output logic [DATA_W-1:0] rd, output logic er);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = wd;
        @(negedge i_clk);
        check_err("o_pready", 1'b0, o_pready);         // first access cycle is a wait
        i_penable = 1'b1;
        @(negedge i_clk);
        while (!o_pready) begin
            @(negedge i_clk);
        end
        rd = o_prdata;                                 // stable mid cycle
        er = o_pslverr;
        @(negedge i_clk);                              // completing edge has passed
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic run_checked(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wd,
                               output logic [DATA_W-1:0] exp_rd, output logic exp_er);
        logic [DATA_W-1:0] rd;
        logic              er;
        model_xfer(wr, addr, wd, exp_rd, exp_er);
        apb_xfer(wr, addr, wd, rd, er);
        check_err("o_pslverr", exp_er, er);
        if (!wr) begin
            check_data("o_prdata", exp_rd, rd);
        end
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input int sel, input logic [3:0] op);
        return {4'(sel), op};
    endfunction

    initial begin
        i_clk      = 1'b0;
        i_reset    = 1'b1;
        i_psel     = 1'b0;
        i_penable  = 1'b0;
        i_pwrite   = 1'b0;
        i_paddr    = '0;
        i_pwdata   = '0;
        stim_ready = 1'b0;
        seed       = 32'ha42a_359b;
        for (int s = 0; s < NUM_STACKS; s++) begin
            m_count[s] = 0;
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            $display("Test failures found");
            $fatal(1, "missing stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin  // skip comments and blanks
                if ($sscanf(line, "%h %h %h %h %h", f_wr, f_addr, f_wd, f_rd, f_er) == 5) begin
                    q_wr.push_back(f_wr);
                    q_addr.push_back(f_addr);
                    q_wd.push_back(f_wd);
                    q_rd.push_back(f_rd);
                    q_er.push_back(f_er);
                end
            end
        end
        $fclose(fd);
        stim_ready = 1'b1;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;

        // directed transfers from the file
        for (int n = 0; n < q_wr.size(); n++) begin
            run_checked(q_wr[n], q_addr[n], q_wd[n], m_rd, m_er);
            if (m_rd !== q_rd[n] || m_er !== q_er[n]) begin
                $display("stim line %0d disagrees with the stack model", n + 1);
                $display("Test failures found");
                $fatal(1, "stimulus and model differ");
            end
        end

        // overfill stack 1, newest DEPTH values come back
        for (int k = 0; k < DEPTH + 3; k++) begin
            run_checked(1'b1, make_addr(1, stack_pkg::OP_PUSH), 16'h0b00 + 16'(k), m_rd, m_er);
        end
        run_checked(1'b0, make_addr(1, stack_pkg::OP_COUNT), '0, m_rd, m_er);
        check_data("o_prdata", DATA_W'(DEPTH), m_rd);
        for (int k = 0; k < DEPTH; k++) begin
            run_checked(1'b0, make_addr(1, stack_pkg::OP_POP), '0, m_rd, m_er);
            check_data("o_prdata", 16'h0b00 + 16'(DEPTH + 2 - k), m_rd);
        end
        run_checked(1'b0, make_addr(1, stack_pkg::OP_COUNT), '0, m_rd, m_er);

        // random traffic, pushes weighted up so stacks fill
        for (int n = 0; n < N_RANDOM; n++) begin
            pick  = int'($unsigned($random(seed)) % 20);
            r_op  = (pick < 5) ? 4'(stack_pkg::OP_PUSH) : 4'(pick - 5);
            r_sel = 4'($unsigned($random(seed)) % 5);   // 4 is out of range
            r_wr  = (r_op < 4'h8);
            if (($random(seed) & 15) == 0) begin
                r_wr = ~r_wr;                          // occasional direction mismatch
            end
            r_wd  = 16'($random(seed));
            run_checked(r_wr, {r_sel, r_op}, r_wd, m_rd, m_er);
        end
        $display("All tests passed!");
        $finish;
    end

    // watchdog, four cycles per transfer plus reset margin
    initial begin
        wait (stim_ready);
        repeat ((q_wr.size() + N_FILL + N_RANDOM) * 4 + 20) @(posedge i_clk);
        $display("timeout, the DUT stopped completing APB transfers");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb/stack_bank_properties.sv */
// stack bank protocol and occupancy checks
// bound into stack_bank_top; watches the wait state, pop strobes and counts

module stack_bank_properties #(
    parameter int NUM_STACKS = 4,                      // stacks in the bank
    parameter int DEPTH      = 12                      // elements per stack
) (
    input  logic                                     i_clk,
    input  logic                                     i_reset,
    input  logic                                     i_pready,
    input  logic [NUM_STACKS-1:0]                    i_pop,
    input  logic [NUM_STACKS*$clog2(DEPTH + 1)-1:0]  i_count_all
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic counts_ok;                                   // no stack above DEPTH
    logic pops_ok;                                     // no pop strobe on an empty stack

    always_comb begin
        counts_ok = 1'b1;
        pops_ok   = 1'b1;
        for (int i = 0; i < NUM_STACKS; i++) begin
            if (i_count_all[i*CNT_W +: CNT_W] > CNT_W'(DEPTH)) begin
                counts_ok = 1'b0;
            end
            if (i_pop[i] && i_count_all[i*CNT_W +: CNT_W] == '0) begin
                pops_ok = 1'b0;                        // decoder depth check missed
            end
        end
    end

    single_wait: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pready |=> !i_pready) else $error("pready high on two cycles in a row");

    no_empty_pop: assert property (@(posedge i_clk) disable iff (i_reset)
        pops_ok) else $error("pop strobe reached an empty stack");

    depth_limit: assert property (@(posedge i_clk) disable iff (i_reset)
        counts_ok) else $error("stack count above DEPTH");

endmodule

bind stack_bank_top stack_bank_properties #(
    .NUM_STACKS (NUM_STACKS),
    .DEPTH      (DEPTH)
) u_props (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_pready    (o_pready),
    .i_pop       (pop),
    .i_count_all (count_all)
);

/* logic/stack_bank_top.sv */
// stack bank top level
// APB decoder driving NUM_STACKS lifo stacks, with the datapath mux
// feeding write data back to the stacks and read data to the bus

module stack_bank_top #(
    parameter int DATA_W     = 16,                       // element width
    parameter int DEPTH      = 12,                       // elements per stack
    parameter int NUM_STACKS = 4                         // at most 16
) (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_psel,
    input  logic                             i_penable,
    input  logic                             i_pwrite,
    input  logic [stack_pkg::ADDR_W-1:0]     i_paddr,
    input  logic [DATA_W-1:0]                i_pwdata,
    output logic [DATA_W-1:0]                o_prdata,
    output logic                             o_pready,
    output logic                             o_pslverr
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [NUM_STACKS-1:0]          push;                // one-hot strobes
    logic [NUM_STACKS-1:0]          pop;
    logic [DATA_W-1:0]              wdata;               // shared by all stacks
    logic [DATA_W-1:0]              rdata;
    logic [CNT_W-1:0]               sel_count;
    logic [NUM_STACKS*DATA_W-1:0]   s0_all;              // flattened stack outputs
    logic [NUM_STACKS*DATA_W-1:0]   s1_all;
    logic [NUM_STACKS*CNT_W-1:0]    count_all;

    apb_stack_decode #(
        .NUM_STACKS (NUM_STACKS),
        .DEPTH      (DEPTH),
        .DATA_W     (DATA_W)
    ) u_decode (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_rdata     (rdata),
        .i_sel_count (sel_count),
        .o_pready    (o_pready),
        .o_prdata    (o_prdata),
        .o_pslverr   (o_pslverr),
        .o_push      (push),
        .o_pop       (pop)
    );

    for (genvar g = 0; g < NUM_STACKS; g++) begin : g_stack
        lifo #(
            .DATA_W (DATA_W),
            .DEPTH  (DEPTH)
        ) u_lifo (
            .i_clk   (i_clk),
            .i_reset (i_reset),
            .i_data  (wdata),
            .i_push  (push[g]),
            .i_pop   (pop[g]),
            .o_s0    (s0_all[g*DATA_W +: DATA_W]),
            .o_s1    (s1_all[g*DATA_W +: DATA_W]),
            .o_count (count_all[g*CNT_W +: CNT_W])
        );
    end

    stack_alu #(
        .NUM_STACKS (NUM_STACKS),
        .DEPTH      (DEPTH),
        .DATA_W     (DATA_W)
    ) u_alu (
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .i_s0_all    (s0_all),
        .i_s1_all    (s1_all),
        .i_count_all (count_all),
        .o_wdata     (wdata),
        .o_rdata     (rdata),
        .o_sel_count (sel_count)
    );

endmodule

/* logic/stack_alu.sv */
// stack bank datapath
// picks the addressed stack's top two elements and count, computes s1 op s0,
// and forms the shared stack write data and the APB read value

module stack_alu #(
    parameter int NUM_STACKS = 4,                        // stacks in the bank
    parameter int DEPTH      = 12,                       // elements per stack
    parameter int DATA_W     = 16                        // element width
) (
    input  logic [stack_pkg::ADDR_W-1:0]                  i_paddr,
    input  logic [DATA_W-1:0]                             i_pwdata,
    input  logic [NUM_STACKS*DATA_W-1:0]                  i_s0_all,    // stack i at slice i
    input  logic [NUM_STACKS*DATA_W-1:0]                  i_s1_all,
    input  logic [NUM_STACKS*$clog2(DEPTH + 1)-1:0]       i_count_all,
    output logic [DATA_W-1:0]                             o_wdata,     // to every lifo
    output logic [DATA_W-1:0]                             o_rdata,     // to decoder
    output logic [$clog2(DEPTH + 1)-1:0]                  o_sel_count  // for depth check
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    stack_pkg::stack_op_e          op;
    logic [stack_pkg::SEL_W-1:0]   sel;
    logic [DATA_W-1:0]             s0;
    logic [DATA_W-1:0]             s1;
    logic [CNT_W-1:0]              cnt;
    logic [DATA_W-1:0]             result;
    logic                          is_alu;

    assign op  = stack_pkg::stack_op_e'(i_paddr[stack_pkg::OP_W-1:0]);
    assign sel = i_paddr[stack_pkg::SEL_LSB +: stack_pkg::SEL_W];

    // stack select mux, out of range index reads as zero
    always_comb begin
        s0  = '0;
        s1  = '0;
        cnt = '0;
        for (int i = 0; i < NUM_STACKS; i++) begin
            if (int'(sel) == i) begin
                s0  = i_s0_all[i*DATA_W +: DATA_W];
                s1  = i_s1_all[i*DATA_W +: DATA_W];
                cnt = i_count_all[i*CNT_W +: CNT_W];
            end
        end
    end

    assign o_sel_count = cnt;

    // s1 op s0, arithmetic wraps at DATA_W
    always_comb begin
        is_alu = 1'b1;
        case (op)
            stack_pkg::OP_ADD: result = s1 + s0;
            stack_pkg::OP_SUB: result = s1 - s0;
            stack_pkg::OP_AND: result = s1 & s0;
            stack_pkg::OP_OR:  result = s1 | s0;
            stack_pkg::OP_XOR: result = s1 ^ s0;
            default: begin
                is_alu = 1'b0;
                result = '0;
            end
        endcase
    end

    assign o_wdata = is_alu ? result : i_pwdata;         // push and repl take pwdata

    // read value, errors filtered in the decoder
    always_comb begin
        case (op)
            stack_pkg::OP_POP,
            stack_pkg::OP_PEEK0: o_rdata = s0;
            stack_pkg::OP_PEEK1: o_rdata = s1;
            stack_pkg::OP_COUNT: o_rdata = DATA_W'(cnt);  // zero extended
            default:             o_rdata = '0;
        endcase
    end

endmodule

/* logic/apb_stack_decode.sv */
// APB slave front end for the stack bank
// one wait state per access; checks op, direction, stack index and depth,
// then fires the push/pop strobes and registers the response

module apb_stack_decode #(
    parameter int NUM_STACKS = 4,                        // stacks behind this slave
    parameter int DEPTH      = 12,                       // elements per stack
    parameter int DATA_W     = 16                        // element width
) (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_psel,
    input  logic                             i_penable,
    input  logic                             i_pwrite,
    input  logic [stack_pkg::ADDR_W-1:0]     i_paddr,
    input  logic [DATA_W-1:0]                i_rdata,     // read value from alu mux
    input  logic [$clog2(DEPTH + 1)-1:0]     i_sel_count, // count of addressed stack
    output logic                             o_pready,
    output logic [DATA_W-1:0]                o_prdata,
    output logic                             o_pslverr,
    output logic [NUM_STACKS-1:0]            o_push,      // one-hot push strobe
    output logic [NUM_STACKS-1:0]            o_pop        // one-hot pop strobe
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    stack_pkg::stack_op_e          op;
    logic [stack_pkg::SEL_W-1:0]   sel;
    logic [NUM_STACKS-1:0]         sel_hot;
    logic [CNT_W-1:0]              need;                 // min elements for the op
    logic                          op_valid;
    logic                          op_is_wr;
    logic                          want_push;
    logic                          want_pop;
    logic                          err;
    logic                          access_wait;          // first access cycle

    assign op          = stack_pkg::stack_op_e'(i_paddr[stack_pkg::OP_W-1:0]);
    assign sel         = i_paddr[stack_pkg::SEL_LSB +: stack_pkg::SEL_W];
    assign sel_hot     = NUM_STACKS'(1) << sel;
    assign access_wait = i_psel & i_penable & ~o_pready; // o_pready doubles as wait flag

    // op classification
    always_comb begin
        op_valid  = 1'b1;
        op_is_wr  = 1'b0;
        need      = '0;
        want_push = 1'b0;
        want_pop  = 1'b0;
        case (op)
            stack_pkg::OP_PUSH: begin
                op_is_wr  = 1'b1;
                want_push = 1'b1;
            end
            stack_pkg::OP_REPL: begin
                op_is_wr  = 1'b1;
                need      = CNT_W'(1);
                want_push = 1'b1;
                want_pop  = 1'b1;
            end
            stack_pkg::OP_ADD, stack_pkg::OP_SUB, stack_pkg::OP_AND,
            stack_pkg::OP_OR, stack_pkg::OP_XOR: begin
                op_is_wr  = 1'b1;
                need      = CNT_W'(2);                   // needs s0 and s1
                want_push = 1'b1;                        // push+pop = replace top
                want_pop  = 1'b1;
            end
            stack_pkg::OP_POP: begin
                need      = CNT_W'(1);
                want_pop  = 1'b1;
            end
            stack_pkg::OP_PEEK0: need = CNT_W'(1);
            stack_pkg::OP_PEEK1: need = CNT_W'(2);
            stack_pkg::OP_COUNT: need = '0;              // always allowed
            default: op_valid = 1'b0;                    // undefined code
        endcase
    end

    assign err = ~op_valid
               | (op_is_wr != i_pwrite)                  // direction mismatch
               | (int'(sel) >= NUM_STACKS)               // no such stack
               | (i_sel_count < need);                   // too few elements

    // handshake, strobes and error flag
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
            o_push    <= '0;
            o_pop     <= '0;
        end else if (access_wait) begin                  // next cycle completes
            o_pready  <= 1'b1;
            o_pslverr <= err;
            o_push    <= (want_push & ~err) ? sel_hot : '0;
            o_pop     <= (want_pop & ~err) ? sel_hot : '0;
        end else begin
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
            o_push    <= '0;
            o_pop     <= '0;
        end
    end

    // read data captured before the pop lands
    always_ff @(posedge i_clk) begin
        if (access_wait) begin
            o_prdata <= (err | i_pwrite) ? '0 : i_rdata;
        end
    end

endmodule

/* logic/lifo.sv */
// lifo stack of DEPTH elements
// push shifts down and writes the top, pop shifts up, push with pop
// rewrites only the top; tracks how many elements are held

module lifo #(
    parameter int DATA_W = 16,                           // bits per element
    parameter int DEPTH  = 12                            // number of elements, at least 2
) (
    input  logic                             i_clk,      // system clock
    input  logic                             i_reset,    // sync reset, clears count only
    input  logic [DATA_W-1:0]                i_data,     // new top value
    input  logic                             i_push,     // push request
    input  logic                             i_pop,      // pop request
    output logic [DATA_W-1:0]                o_s0,       // top of stack
    output logic [DATA_W-1:0]                o_s1,       // next on stack
    output logic [$clog2(DEPTH + 1)-1:0]     o_count     // elements held
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] elem [0:DEPTH-1];                 // elem[0] is the top
    logic [CNT_W-1:0]  count_q;

    assign o_s0    = elem[0];
    assign o_s1    = elem[1];
    assign o_count = count_q;

    // element chain
    always_ff @(posedge i_clk) begin
        case ({i_push, i_pop})
            2'b11: begin                                 // replace top
                elem[0] <= i_data;
            end
            2'b10: begin                                 // push, bottom falls off
                elem[0] <= i_data;
                for (int i = 1; i < DEPTH; i++) begin
                    elem[i] <= elem[i-1];
                end
            end
            2'b01: begin                                 // pop, bottom keeps its value
                for (int i = 0; i < DEPTH - 1; i++) begin
                    elem[i] <= elem[i+1];
                end
            end
            default: begin                               // idle
            end
        endcase
    end

    // occupancy, saturates at both ends
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count_q <= '0;
        end else begin
            case ({i_push, i_pop})
                2'b10: begin
                    if (count_q != CNT_W'(DEPTH)) begin  // full push keeps DEPTH
                        count_q <= count_q + 1'b1;
                    end
                end
                2'b01: begin
                    if (count_q != '0) begin             // guard, decoder blocks this
                        count_q <= count_q - 1'b1;
                    end
                end
                default: begin                           // replace or idle, no change
                end
            endcase
        end
    end

endmodule

/* logic/stack_pkg.sv */
// stack bank shared definitions
// operation codes carried in the low address bits and the APB address field layout

package stack_pkg;

    localparam int OP_W    = 4;                          // op field in paddr[3:0]
    localparam int SEL_LSB = 4;                          // stack select starts here
    localparam int ADDR_W  = 8;                          // apb address width
    localparam int SEL_W   = ADDR_W - SEL_LSB;           // up to 16 stacks

    // op codes, writes in the low half, reads in the high half
    typedef enum logic [OP_W-1:0] {
        OP_PUSH  = 4'h0,                                 // push pwdata
        OP_REPL  = 4'h1,                                 // replace top with pwdata
        OP_ADD   = 4'h2,                                 // top <= s1 + s0
        OP_SUB   = 4'h3,                                 // top <= s1 - s0
        OP_AND   = 4'h4,                                 // top <= s1 & s0
        OP_OR    = 4'h5,                                 // top <= s1 | s0
        OP_XOR   = 4'h6,                                 // top <= s1 ^ s0
        OP_POP   = 4'h8,                                 // read and remove top
        OP_PEEK0 = 4'h9,                                 // read top
        OP_PEEK1 = 4'ha,                                 // read second element
        OP_COUNT = 4'hb                                  // read occupancy
    } stack_op_e;

    // codes 7 and c..f are undefined and answer with pslverr

endpackage
